//--- src/pool_pkg.sv
package pool_pkg;

	// Engine geometry
	localparam int BURST_LEN    = 16;  // Lanes per atom, words per burst
	localparam int LANE_W       = 16;  // One data word
	localparam int WIN_LOG2_MAX = 4;   // Window of up to 16 atoms
	localparam int FIFO_DEPTH   = 4;   // Atoms held between deserializer and reducer

	// Derived widths
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // FIFO pointer width
	localparam int LANE_CNT_W = $clog2(BURST_LEN);   // Word index inside a burst

	// One signed data word
	typedef logic signed [LANE_W-1:0] lane_t;

	// Whole atom, lane 0 in the low bits
	typedef logic [BURST_LEN*LANE_W-1:0] atom_t;

	// Per-lane accumulator, room for 16 summed words
	typedef logic signed [LANE_W+WIN_LOG2_MAX-1:0] acc_t;

	typedef logic [2:0]  win_log2_t;  // Window exponent 0..4
	typedef logic [15:0] count_t;     // Windows per command

	// Pooling operation
	typedef enum logic {
		OP_MAX,  // Max pooling
		OP_AVG   // Average pooling
	} pool_op_t;

	// Deserializer FSM
	typedef enum logic [1:0] {
		DS_IDLE,
		DS_REQUEST,
		DS_PUSH
	} deser_state_t;

	// Reducer FSM
	typedef enum logic [1:0] {
		RS_IDLE,
		RS_GATHER,
		RS_EMIT,
		RS_DRAIN
	} reduce_state_t;

endpackage

//--- src/burst_deserializer.sv
module burst_deserializer import pool_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      i_start,        // Accepted command
	input  win_log2_t i_win_log2,
	input  count_t    i_num_windows,
	input  logic      i_rd_we,        // Word strobe from source
	input  lane_t     i_rd_data,
	input  logic      i_fifo_ready,   // Room for one more atom
	output logic      o_rd_en,        // Burst request
	output logic      o_filling,      // Burst in progress, atom not yet pushed
	output logic      o_push,
	output atom_t     o_push_atom
);

	deser_state_t state;
	logic [$bits(count_t)+WIN_LOG2_MAX-1:0] bursts_left;  // Bursts not yet started
	logic [LANE_CNT_W-1:0] word_cnt;  // Position inside current burst
	atom_t shift_q;                   // Assembly register, first word ends in lane 0

	// Only request while bursts remain and the FIFO can take the atom
	assign o_rd_en = (state == DS_REQUEST) && (bursts_left != '0) && i_fifo_ready;
	assign o_push = (state == DS_PUSH);  // One cycle after last strobe
	assign o_push_atom = shift_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= DS_IDLE;
			bursts_left <= '0;
			word_cnt <= '0;
			o_filling <= 1'b0;
		end else begin
			case (state)
				DS_IDLE: begin
					if (i_start && (i_num_windows != '0)) begin
						// Atoms = windows * 2^exp
						bursts_left <= {{WIN_LOG2_MAX{1'b0}}, i_num_windows} << i_win_log2;
						word_cnt <= '0;
						state <= DS_REQUEST;
					end
				end
				DS_REQUEST: begin
					if (i_rd_we) begin
						word_cnt <= word_cnt + 1'b1;
						if (word_cnt == '0) begin  // First word opens a burst
							bursts_left <= bursts_left - 1'b1;
							o_filling <= 1'b1;
						end
						if (word_cnt == LANE_CNT_W'(BURST_LEN - 1)) begin
							state <= DS_PUSH;  // Atom complete
						end
					end
				end
				DS_PUSH: begin
					o_filling <= 1'b0;  // Atom now counted by the FIFO
					word_cnt <= '0;
					state <= (bursts_left == '0) ? DS_IDLE : DS_REQUEST;
				end
				default: state <= DS_IDLE;
			endcase
		end
	end

	// Shift register, new word enters the top lane
	always_ff @(posedge clk) begin
		if ((state == DS_REQUEST) && i_rd_we) begin
			shift_q <= {i_rd_data, shift_q[BURST_LEN*LANE_W-1:LANE_W]};
		end
	end

endmodule

//--- src/atom_fifo.sv
module atom_fifo import pool_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  i_push,       // Write one atom
	input  atom_t i_push_atom,
	input  logic  i_filling,    // An atom is being assembled upstream
	input  logic  i_pop,        // Take the head
	output logic  o_valid,      // Head available
	output atom_t o_atom,       // Show-ahead head
	output logic  o_ready       // Space for one more burst
);

	atom_t mem [FIFO_DEPTH];  // Circular buffer

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;   // Occupancy 0..FIFO_DEPTH

	logic do_push;
	logic do_pop;

	assign do_push = i_push;
	assign do_pop = i_pop && o_valid;  // Never pop an empty buffer

	assign o_valid = (count != '0);
	assign o_atom = mem[rd_ptr];

	// Reserve a slot for the atom still in flight
	assign o_ready = (int'(count) + int'(i_filling)) < FIFO_DEPTH;

	// Pointers and occupancy
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Idle or simultaneous push and pop
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_push_atom;
		end
	end

endmodule

//--- src/pool_reducer.sv
module pool_reducer import pool_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      i_start,
	input  pool_op_t  i_op,
	input  win_log2_t i_win_log2,
	input  count_t    i_num_windows,
	input  logic      i_valid,       // FIFO head present
	input  atom_t     i_atom,
	input  logic      i_ser_idle,    // Serializer can take a result
	output logic      o_pop,
	output logic      o_load,
	output atom_t     o_result,
	output logic      o_busy,
	output logic      o_done
);

	reduce_state_t state;

	// Latched command
	pool_op_t  op_q;
	win_log2_t win_q;
	count_t    windows_left;

	logic [WIN_LOG2_MAX-1:0] atom_idx;  // Atom index inside the window
	logic [WIN_LOG2_MAX-1:0] last_idx;  // Window length minus one

	lane_t in_lane [BURST_LEN];  // Head atom split into lanes
	acc_t  acc [BURST_LEN];      // Running max or running sum

	assign last_idx = WIN_LOG2_MAX'((1 << win_q) - 1);

	assign o_pop = (state == RS_GATHER) && i_valid;   // One atom per cycle
	assign o_load = (state == RS_EMIT) && i_ser_idle;
	assign o_busy = (state != RS_IDLE);

	always_comb begin
		for (int l = 0; l < BURST_LEN; l++) begin
			in_lane[l] = i_atom[l*LANE_W +: LANE_W];
		end
	end

	// Result forming, max passes through and average is a floor shift
	always_comb begin
		acc_t shifted;
		for (int l = 0; l < BURST_LEN; l++) begin
			shifted = (op_q == OP_AVG) ? (acc[l] >>> win_q) : acc[l];
			o_result[l*LANE_W +: LANE_W] = shifted[LANE_W-1:0];  // Always fits a word
		end
	end

	// Control FSM
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= RS_IDLE;
			op_q <= OP_MAX;
			win_q <= '0;
			windows_left <= '0;
			atom_idx <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				RS_IDLE: begin
					if (i_start) begin
						op_q <= i_op;
						win_q <= i_win_log2;
						windows_left <= i_num_windows;
						atom_idx <= '0;
						state <= (i_num_windows == '0) ? RS_DRAIN : RS_GATHER;
					end
				end
				RS_GATHER: begin
					if (i_valid) begin
						atom_idx <= atom_idx + 1'b1;
						if (atom_idx == last_idx) begin  // Window complete
							atom_idx <= '0;
							state <= RS_EMIT;
						end
					end
				end
				RS_EMIT: begin
					if (i_ser_idle) begin  // Stall while serializer is busy
						windows_left <= windows_left - 1'b1;
						state <= (windows_left == count_t'(1)) ? RS_DRAIN : RS_GATHER;
					end
				end
				RS_DRAIN: begin
					// Serializer idle here means its last word is on the bus
					if (i_ser_idle) begin
						o_done <= 1'b1;
						state <= RS_IDLE;
					end
				end
				default: state <= RS_IDLE;
			endcase
		end
	end

	// Per-lane fold, first atom of a window initialises
	always_ff @(posedge clk) begin
		if (o_pop) begin
			for (int l = 0; l < BURST_LEN; l++) begin
				if (atom_idx == '0) begin
					acc[l] <= acc_t'(in_lane[l]);
				end else if (op_q == OP_MAX) begin
					if (acc_t'(in_lane[l]) > acc[l]) acc[l] <= acc_t'(in_lane[l]);  // Signed max
				end else begin
					acc[l] <= acc[l] + acc_t'(in_lane[l]);
				end
			end
		end
	end

endmodule

//--- src/writeback_serializer.sv
module writeback_serializer import pool_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  i_load,      // Take a result atom
	input  atom_t i_result,
	output logic  o_idle,      // Free for a new load next cycle
	output logic  o_wr_en,     // Word strobe
	output lane_t o_wr_data
);

	atom_t data_q;                    // Remaining lanes, current word at the bottom
	logic [LANE_CNT_W-1:0] lane_cnt;  // Words already sent
	logic active;
	logic last_word;

	assign last_word = (lane_cnt == LANE_CNT_W'(BURST_LEN - 1));

	// Idle during the last word so results can follow back to back
	assign o_idle = !active || last_word;
	assign o_wr_en = active;
	assign o_wr_data = data_q[LANE_W-1:0];  // Lane 0 first

	// Strobe control
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			lane_cnt <= '0;
		end else begin
			if (i_load) begin
				active <= 1'b1;
				lane_cnt <= '0;
			end else if (active) begin
				lane_cnt <= lane_cnt + 1'b1;
				if (last_word) begin
					active <= 1'b0;  // BURST_LEN words sent
				end
			end
		end
	end

	// Payload shift, one lane per strobe
	always_ff @(posedge clk) begin
		if (i_load) begin
			data_q <= i_result;
		end else if (active) begin
			data_q <= data_q >> LANE_W;
		end
	end

endmodule

//--- src/pool_engine.sv
module pool_engine import pool_pkg::*; (
	input  logic      clk,
	input  logic      rst,

	// Command
	input  logic      i_start,
	input  pool_op_t  i_op,
	input  win_log2_t i_win_log2,
	input  count_t    i_num_windows,

	// Read stream
	output logic      o_rd_en,
	input  logic      i_rd_we,
	input  lane_t     i_rd_data,

	// Write stream, no back-pressure
	output logic      o_wr_en,
	output lane_t     o_wr_data,

	// Status
	output logic      o_busy,
	output logic      o_done
);

	logic  start_go;     // Start seen while idle
	logic  fifo_ready;
	logic  filling;
	logic  push;
	atom_t push_atom;
	logic  fifo_valid;
	atom_t fifo_atom;
	logic  pop;
	logic  load;
	atom_t result;
	logic  ser_idle;

	// A start during a command is dropped
	assign start_go = i_start && !o_busy;

	burst_deserializer burst_deserializer_i (
		.clk           (clk),
		.rst           (rst),
		.i_start       (start_go),
		.i_win_log2    (i_win_log2),
		.i_num_windows (i_num_windows),
		.i_rd_we       (i_rd_we),
		.i_rd_data     (i_rd_data),
		.i_fifo_ready  (fifo_ready),
		.o_rd_en       (o_rd_en),
		.o_filling     (filling),
		.o_push        (push),
		.o_push_atom   (push_atom)
	);

	atom_fifo atom_fifo_i (
		.clk         (clk),
		.rst         (rst),
		.i_push      (push),
		.i_push_atom (push_atom),
		.i_filling   (filling),
		.i_pop       (pop),
		.o_valid     (fifo_valid),
		.o_atom      (fifo_atom),
		.o_ready     (fifo_ready)
	);

	pool_reducer pool_reducer_i (
		.clk           (clk),
		.rst           (rst),
		.i_start       (start_go),
		.i_op          (i_op),
		.i_win_log2    (i_win_log2),
		.i_num_windows (i_num_windows),
		.i_valid       (fifo_valid),
		.i_atom        (fifo_atom),
		.i_ser_idle    (ser_idle),
		.o_pop         (pop),
		.o_load        (load),
		.o_result      (result),
		.o_busy        (o_busy),
		.o_done        (o_done)
	);

	writeback_serializer writeback_serializer_i (
		.clk       (clk),
		.rst       (rst),
		.i_load    (load),
		.i_result  (result),
		.o_idle    (ser_idle),
		.o_wr_en   (o_wr_en),
		.o_wr_data (o_wr_data)
	);

endmodule

//--- testbench/pool_case_driver.sv
module pool_case_driver import pool_pkg::*; (
	input  logic      clk,
	input  logic      i_rd_en,        // Burst request from DUT
	output logic      o_start,
	output pool_op_t  o_op,
	output win_log2_t o_win_log2,
	output count_t    o_num_windows,
	output logic      o_rd_we,
	output lane_t     o_rd_data
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RD_EN_WAIT_MAX = 2000;  // Cycles a burst may wait for o_rd_en

	// Case table filled from the cases file
	int    c_op[$];
	int    c_win[$];
	int    c_nwin[$];
	int    c_dup[$];       // Second start while busy
	int    c_in_first[$];
	int    c_in_cnt[$];
	int    c_out_first[$];
	int    c_out_cnt[$];
	lane_t in_words[$];
	lane_t out_words[$];

	int seed = 31794;
	bit loaded = 0;
	int stall_flag;  // Set when a burst never got o_rd_en

	// Expand one ramp spec into n atoms of base + k*astep + lane*lstep
	task automatic expand_ramp(input int fd, input bit to_out);
		int n, base, astep, lstep, r;
		r = $fscanf(fd, "%d %d %d %d", n, base, astep, lstep);
		for (int k = 0; k < n; k++) begin
			for (int l = 0; l < BURST_LEN; l++) begin
				if (to_out) out_words.push_back(lane_t'(base + k*astep + l*lstep));
				else in_words.push_back(lane_t'(base + k*astep + l*lstep));
			end
		end
		if (to_out) c_out_cnt[c_out_cnt.size()-1] += n*BURST_LEN;
		else c_in_cnt[c_in_cnt.size()-1] += n*BURST_LEN;
	endtask

	// One explicit atom of BURST_LEN words
	task automatic read_atom(input int fd, input bit to_out);
		int v, r;
		for (int l = 0; l < BURST_LEN; l++) begin
			r = $fscanf(fd, "%d", v);
			if (to_out) out_words.push_back(lane_t'(v));
			else in_words.push_back(lane_t'(v));
		end
		if (to_out) c_out_cnt[c_out_cnt.size()-1] += BURST_LEN;
		else c_in_cnt[c_in_cnt.size()-1] += BURST_LEN;
	endtask

	task automatic load_cases();
		int fd, r, op, win, nwin, dup;
		logic [63:0] tok;
		logic [8*200-1:0] line;
		fd = $fopen("testbench/pool_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/pool_cases.txt");
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") r = $fgets(line, fd);  // Rest of a comment line
			else if (tok == "case") begin
				r = $fscanf(fd, "%d %d %d %d", op, win, nwin, dup);
				c_op.push_back(op);
				c_win.push_back(win);
				c_nwin.push_back(nwin);
				c_dup.push_back(dup);
				c_in_first.push_back(in_words.size());
				c_out_first.push_back(out_words.size());
				c_in_cnt.push_back(0);
				c_out_cnt.push_back(0);
			end
			else if (tok == "ir") expand_ramp(fd, 0);
			else if (tok == "or") expand_ramp(fd, 1);
			else if (tok == "iw") read_atom(fd, 0);
			else if (tok == "ow") read_atom(fd, 1);
		end
		$fclose(fd);
	endtask

	// Command pulse and then all bursts of the case with random gaps
	task automatic drive_case(input int idx);
		int gap, waited, first;
		first = c_in_first[idx];
		stall_flag = 0;
		@(negedge clk);
		o_start = 1'b1;
		o_op = pool_op_t'(c_op[idx]);
		o_win_log2 = win_log2_t'(c_win[idx]);
		o_num_windows = count_t'(c_nwin[idx]);
		@(negedge clk);
		o_start = 1'b0;
		for (int a = 0; a < c_in_cnt[idx] / BURST_LEN; a++) begin
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) @(negedge clk);
			waited = 0;
			while (!i_rd_en && waited < RD_EN_WAIT_MAX) begin  // Only start on a request
				@(negedge clk);
				waited++;
			end
			if (!i_rd_en) begin
				$display("source waited %0d cycles for o_rd_en before burst %0d, giving up",
					RD_EN_WAIT_MAX, a);
				stall_flag = 1;
				return;
			end
			for (int w = 0; w < BURST_LEN; w++) begin
				o_rd_we = 1'b1;
				o_rd_data = in_words[first + a*BURST_LEN + w];
				@(negedge clk);
				gap = $unsigned($random(seed)) % 3;
				if (w < BURST_LEN - 1 && gap != 0) begin
					o_rd_we = 1'b0;  // Hole inside the burst
					repeat (gap) @(negedge clk);
				end
			end
			o_rd_we = 1'b0;
		end
		if (c_dup[idx] != 0) begin
			// Deserializer back in idle while the reducer still works on the last window
			repeat (2) @(negedge clk);
			o_start = 1'b1;  // Must be dropped by the busy DUT
			o_op = (o_op == OP_MAX) ? OP_AVG : OP_MAX;
			o_win_log2 = '0;
			o_num_windows = count_t'(7);
			@(negedge clk);
			o_start = 1'b0;
		end
	endtask

	initial begin
		o_start = 1'b0;
		o_op = OP_MAX;
		o_win_log2 = '0;
		o_num_windows = '0;
		o_rd_we = 1'b0;
		o_rd_data = '0;
		stall_flag = 0;
		load_cases();
		loaded = 1;
	end

endmodule

//--- testbench/pool_engine_tb.sv
module pool_engine_tb import pool_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;

	logic      clk;
	logic      rst;
	logic      start;
	pool_op_t  op;
	win_log2_t win_log2;
	count_t    num_windows;
	logic      rd_en;
	logic      rd_we;
	lane_t     rd_data;
	logic      wr_en;
	lane_t     wr_data;
	logic      busy;
	logic      done;

	int errors;      // Errors in the running case
	int pass_cnt;
	int fail_cnt;

	pool_engine pool_engine_i (
		.clk           (clk),
		.rst           (rst),
		.i_start       (start),
		.i_op          (op),
		.i_win_log2    (win_log2),
		.i_num_windows (num_windows),
		.o_rd_en       (rd_en),
		.i_rd_we       (rd_we),
		.i_rd_data     (rd_data),
		.o_wr_en       (wr_en),
		.o_wr_data     (wr_data),
		.o_busy        (busy),
		.o_done        (done)
	);

	pool_case_driver driver_i (
		.clk           (clk),
		.i_rd_en       (rd_en),
		.o_start       (start),
		.o_op          (op),
		.o_win_log2    (win_log2),
		.o_num_windows (num_windows),
		.o_rd_we       (rd_we),
		.o_rd_data     (rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic compare_lane(input string sig, input lane_t expected, input lane_t actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %0d, got %0d", $time, sig, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_count(input count_t expected, input count_t actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: word count expected %0d, got %0d",
				$time, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_done(input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: o_done expected %b, got %b", $time, expected, actual);
			errors++;
		end
	endtask

	// Status levels such as o_busy after reset
	task automatic compare_flag(input string sig, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %b, got %b", $time, sig, expected, actual);
			errors++;
		end
	endtask

	// Gather write strobes on rising edges and track the done pulse
	task automatic collect_case(input int idx);
		int n_exp, first, n_got, cycle, limit, tail;
		bit done_seen;
		logic prev_wr;
		logic exp_done;
		n_exp = driver_i.c_out_cnt[idx];
		first = driver_i.c_out_first[idx];
		limit = driver_i.c_in_cnt[idx]*4 + n_exp*2 + 200;
		n_got = 0;
		cycle = 0;
		tail = 0;
		done_seen = 0;
		prev_wr = 1'b0;
		while (cycle < limit && tail < 4) begin
			@(posedge clk);
			cycle++;
			exp_done = prev_wr && !wr_en && (n_got == n_exp);  // Right after the last strobe
			compare_done(exp_done, done);
			if (done) begin
				compare_flag("o_busy", 1'b0, busy);  // Busy drops with the done pulse
				done_seen = 1;
			end
			if (wr_en) begin
				compare_flag("o_busy", 1'b1, busy);
				if (n_got < n_exp) begin
					compare_lane("o_wr_data", driver_i.out_words[first + n_got], wr_data);
				end
				n_got++;
			end
			prev_wr = wr_en;
			if (done_seen) begin
				compare_flag("o_rd_en", 1'b0, rd_en);  // No request once the command is over
				tail++;  // A few quiet cycles to catch a second pulse
			end
		end
		if (!done_seen) begin
			$display("case %0d got no done pulse within %0d cycles", idx, limit);
			errors++;
		end
		compare_count(count_t'(n_exp), count_t'(n_got));
	endtask

	// Watchdog sized from the whole case file
	initial begin
		longint cycles;
		wait (driver_i.loaded);
		cycles = driver_i.in_words.size()*4 + driver_i.out_words.size()*2
			+ 200*driver_i.c_op.size();
		#(cycles * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run stopped", cycles);
		$display("Test failures found");
		$finish;
	end

	initial begin
		errors = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		rst = 1'b1;
		wait (driver_i.loaded);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(posedge clk);
		compare_flag("o_busy", 1'b0, busy);
		compare_flag("o_rd_en", 1'b0, rd_en);
		compare_flag("o_wr_en", 1'b0, wr_en);
		compare_flag("o_done", 1'b0, done);
		if (errors == 0) begin
			$display("reset check passed");
			pass_cnt++;
		end else begin
			$display("reset check failed with %0d errors", errors);
			fail_cnt++;
		end
		if (driver_i.c_op.size() == 0) begin
			$display("case file holds no cases");
			fail_cnt++;
		end
		for (int c = 0; c < driver_i.c_op.size(); c++) begin
			errors = 0;
			fork
				driver_i.drive_case(c);
				collect_case(c);
			join
			if (driver_i.stall_flag != 0) errors++;
			if (errors == 0) begin
				$display("case %0d passed", c);
				pass_cnt++;
			end else begin
				$display("case %0d failed with %0d errors", c, errors);
				fail_cnt++;
			end
		end
		$display("%0d cases passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- testbench/pool_cases.txt
# case: op (0 max, 1 avg), window exponent, window count, second start while busy
# ir/or: atom count, base, atom step, lane step   iw/ow: 16 words, lane 0 first
case 0 2 2 0
ir 1 -100 0 10
ir 1 50 0 -10
ir 1 -5 0 0
ir 1 -300 0 30
ir 1 -32768 0 1
ir 1 32767 0 -1
ir 1 0 0 0
ir 1 -1 0 0
ow 50 40 30 20 10 0 -5 -5 -5 -5 0 30 60 90 120 150
or 1 32767 0 -1
case 1 1 1 0
ir 1 -7 0 1
ir 1 0 0 0
ow -4 -3 -3 -2 -2 -1 -1 0 0 1 1 2 2 3 3 4
case 1 3 1 0
ir 4 -1000 0 3
ir 4 999 0 -2
ow -1 0 0 1 1 2 2 3 3 4 4 5 5 6 6 7
case 1 4 1 0
ir 8 -32768 0 0
ir 8 32767 0 -1
ow -1 -1 -2 -2 -3 -3 -4 -4 -5 -5 -6 -6 -7 -7 -8 -8
case 0 0 3 0
iw 3 -1 4 -1 5 -9 2 -6 5 -3 5 -8 9 -7 9 -3
ir 2 100 -250 13
ow 3 -1 4 -1 5 -9 2 -6 5 -3 5 -8 9 -7 9 -3
or 2 100 -250 13
case 1 0 12 0
ir 12 -600 100 7
or 12 -600 100 7
case 0 1 2 1
ir 2 10 5 -1
ir 2 -10 -5 1
or 1 15 0 -1
or 1 -10 0 1

//--- sources.f
src/pool_pkg.sv
src/burst_deserializer.sv
src/atom_fifo.sv
src/pool_reducer.sv
src/writeback_serializer.sv
src/pool_engine.sv
testbench/pool_case_driver.sv
testbench/pool_engine_tb.sv

//--- Bender.yml
package:
  name: pool_engine

sources:
  - src/pool_pkg.sv
  - src/burst_deserializer.sv
  - src/atom_fifo.sv
  - src/pool_reducer.sv
  - src/writeback_serializer.sv
  - src/pool_engine.sv
  - target: test
    files:
      - testbench/pool_case_driver.sv
      - testbench/pool_engine_tb.sv
